// ==== logic/vec_pkg.sv ====
package vec_pkg;

    localparam int LANES      = 4;   // 32-bit lanes per beat
    localparam int LANE_W     = 32;
    localparam int KEEP_W     = LANES * LANE_W / 8;
    localparam int NUM_COL    = 2;
    localparam int RF_DEPTH   = 16;
    localparam int ADDR_W     = 4;
    localparam int CNT_W      = 5;   // len runs 1..16
    localparam int FIFO_DEPTH = 16;
    localparam int MACC_LAT   = 2;   // multiply stage + add stage

    typedef logic [LANE_W-1:0] lane_t;
    typedef lane_t [LANES-1:0] beat_t;
    typedef logic [LANES-1:0]  lane_mask_t;

    typedef enum logic [1:0] {
        OP_LOAD      = 2'd0,
        OP_MACC      = 2'd1,
        OP_STREAMOUT = 2'd2
    } op_e;

    typedef struct packed {
        op_e              op;
        logic             col;   // target column
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [CNT_W-1:0]  len;
        logic             last;  // disarms the loader when done
    } cmd_t;

    // input lane fifo entry
    typedef struct packed {
        lane_t data;
        logic  keep;
    } in_lane_t;

    // output lane fifo entry
    typedef struct packed {
        lane_t data;
        logic  last;
    } out_lane_t;

    typedef struct packed {
        beat_t      data;
        lane_mask_t valid;
        logic       last;
    } chain_t;

endpackage

// ==== logic/lane_fifo.sv ====
module lane_fifo
    import vec_pkg::*;
#(
    parameter type payload_t = logic,
    parameter int  DEPTH     = FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_push,
    input  payload_t i_data,
    input  logic     i_pop,
    output payload_t o_data,
    output logic     o_empty,
    output logic     o_full
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= i_data;
    end

    assign o_data  = mem[rd_ptr];  // head shows the cycle after the push
    assign o_empty = (count == '0);
    assign o_full  = (count == (PTR_W+1)'(DEPTH));

    // upstream flow control must keep these from happening
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) i_push |-> !o_full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) i_pop |-> !o_empty);

endmodule

// ==== logic/stream_ingress.sv ====
module stream_ingress
    import vec_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  beat_t             i_tdata,
    input  logic [KEEP_W-1:0] i_tkeep,
    input  logic              i_tvalid,
    input  logic              i_armed,
    output logic              o_tready,
    input  logic              i_pop,
    output beat_t             o_beat,
    output lane_mask_t        o_keep,
    output logic              o_avail
);

    lane_mask_t lane_full;
    lane_mask_t lane_empty;
    in_lane_t   push_data [LANES];
    in_lane_t   head      [LANES];
    logic       accept;

    assign o_tready = i_armed && !(|lane_full);
    assign accept   = i_tvalid && o_tready;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        // lane kept only when all four of its bytes are kept
        assign push_data[l].data = i_tdata[l];
        assign push_data[l].keep = &i_tkeep[4*l +: 4];

        lane_fifo #(
            .payload_t(in_lane_t),
            .DEPTH    (FIFO_DEPTH)
        ) u_fifo (
            .clk    (clk),
            .rst    (rst),
            .i_push (accept),
            .i_data (push_data[l]),
            .i_pop  (i_pop),
            .o_data (head[l]),
            .o_empty(lane_empty[l]),
            .o_full (lane_full[l])
        );

        assign o_beat[l] = head[l].data;
        assign o_keep[l] = head[l].keep;
    end

    assign o_avail = !(|lane_empty);  // lanes move in lockstep

endmodule

// ==== logic/addr_sequencer.sv ====
module addr_sequencer
    import vec_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_start,
    input  cmd_t              i_cmd,
    input  logic              i_stall,
    output logic [ADDR_W-1:0] o_rd_src,
    output logic [ADDR_W-1:0] o_rd_dst,
    output logic              o_issue,
    output logic              o_last_issue,
    input  logic              i_wr_valid,
    output logic [ADDR_W-1:0] o_wr_addr,
    output logic              o_done
);

    cmd_t             cmd_q;
    logic             issuing;   // read side still has beats to issue
    logic             active;    // whole command, through the last writeback
    logic [CNT_W-1:0] issue_cnt;
    logic [CNT_W-1:0] wb_cnt;
    logic [CNT_W-1:0] last_idx;
    logic             last_wb;
    logic             finish;

    assign last_idx     = cmd_q.len - 1'b1;
    assign o_issue      = issuing && !i_stall;
    assign o_last_issue = o_issue && (issue_cnt == last_idx);

    assign o_rd_src  = cmd_q.src + issue_cnt[ADDR_W-1:0];
    assign o_rd_dst  = cmd_q.dst + issue_cnt[ADDR_W-1:0];
    assign o_wr_addr = cmd_q.dst + wb_cnt[ADDR_W-1:0];

    // streamout writes nothing back, so it ends on the last read
    assign last_wb = i_wr_valid && (wb_cnt == last_idx);
    assign finish  = (cmd_q.op == OP_STREAMOUT) ? o_last_issue : last_wb;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_q     <= '0;
            issuing   <= 1'b0;
            active    <= 1'b0;
            issue_cnt <= '0;
            wb_cnt    <= '0;
            o_done    <= 1'b0;
        end else begin
            o_done <= active && finish;
            if (i_start) begin
                cmd_q     <= i_cmd;
                issuing   <= 1'b1;
                active    <= 1'b1;
                issue_cnt <= '0;
                wb_cnt    <= '0;
            end else begin
                if (o_issue)      issue_cnt <= issue_cnt + 1'b1;
                if (o_last_issue) issuing   <= 1'b0;
                if (i_wr_valid)   wb_cnt    <= wb_cnt + 1'b1;
                if (finish)       active    <= 1'b0;
            end
        end
    end

    // top level must hold back commands until the done pulse
    a_start_idle: assert property (@(posedge clk) disable iff (rst) i_start |-> !active);

endmodule

// ==== logic/vec_regfile.sv ====
module vec_regfile
    import vec_pkg::*;
(
    input  logic              clk,
    input  logic [ADDR_W-1:0] i_rd_addr1,
    input  logic [ADDR_W-1:0] i_rd_addr2,
    output beat_t             o_rd_data1,
    output beat_t             o_rd_data2,
    input  logic [ADDR_W-1:0] i_wr_addr,
    input  beat_t             i_wr_data,
    input  lane_mask_t        i_wr_mask
);

    beat_t mem [RF_DEPTH];

    // registered reads, old data on a same-cycle write
    always_ff @(posedge clk) begin
        o_rd_data1 <= mem[i_rd_addr1];
        o_rd_data2 <= mem[i_rd_addr2];
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (i_wr_mask[l]) mem[i_wr_addr][l] <= i_wr_data[l];
        end
    end

endmodule

// ==== logic/macc_pe.sv ====
module macc_pe
    import vec_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_valid,
    input  beat_t             i_stream,
    input  beat_t             i_mul,
    input  beat_t             i_acc,
    input  logic [ADDR_W-1:0] i_addr,
    output logic              o_valid,
    output beat_t             o_result,
    output logic [ADDR_W-1:0] o_addr
);

    beat_t             prod_q;
    beat_t             acc_q;
    logic              valid_q;
    logic [ADDR_W-1:0] addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            valid_q <= i_valid;
            o_valid <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            prod_q[l]   <= i_stream[l] * i_mul[l];  // low 32 bits only
            o_result[l] <= prod_q[l] + acc_q[l];
        end
        acc_q  <= i_acc;
        addr_q <= i_addr;
        o_addr <= addr_q;
    end

endmodule

// ==== logic/vec_column.sv ====
module vec_column
    import vec_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       i_start,
    input  cmd_t       i_cmd,
    input  beat_t      i_beat,
    input  lane_mask_t i_keep,
    input  logic       i_avail,
    output logic       o_pop,
    input  logic       i_out_full,
    input  chain_t     i_chain,
    output chain_t     o_chain,
    output logic       o_done
);

    op_e               op_q;
    logic              stall;
    logic              issue;
    logic              last_issue;
    logic              wr_valid;
    logic [ADDR_W-1:0] rd_src;
    logic [ADDR_W-1:0] rd_dst;
    logic [ADDR_W-1:0] rd_dst_q;
    logic [ADDR_W-1:0] seq_wr_addr;
    logic [ADDR_W-1:0] pe_addr;
    logic [ADDR_W-1:0] wr_addr;
    beat_t             rd_data1;
    beat_t             rd_data2;
    beat_t             beat_q;
    beat_t             pe_result;
    beat_t             wr_data;
    lane_mask_t        wr_mask;
    logic              pe_valid;
    logic              macc_valid_q;
    logic              so_valid_q;
    logic              so_last_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q         <= OP_LOAD;
            macc_valid_q <= 1'b0;
            so_valid_q   <= 1'b0;
            so_last_q    <= 1'b0;
        end else begin
            if (i_start) op_q <= i_cmd.op;
            macc_valid_q <= issue && (op_q == OP_MACC);
            so_valid_q   <= issue && (op_q == OP_STREAMOUT);
            so_last_q    <= last_issue && (op_q == OP_STREAMOUT);
        end
    end

    // stream beat waits one cycle to meet the register reads
    always_ff @(posedge clk) begin
        beat_q   <= i_beat;
        rd_dst_q <= rd_dst;
    end

    assign stall    = (op_q == OP_STREAMOUT) ? i_out_full : !i_avail;
    assign o_pop    = issue && (op_q != OP_STREAMOUT);
    assign wr_valid = (op_q == OP_MACC) ? pe_valid : o_pop;

    addr_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .i_start     (i_start),
        .i_cmd       (i_cmd),
        .i_stall     (stall),
        .o_rd_src    (rd_src),
        .o_rd_dst    (rd_dst),
        .o_issue     (issue),
        .o_last_issue(last_issue),
        .i_wr_valid  (wr_valid),
        .o_wr_addr   (seq_wr_addr),
        .o_done      (o_done)
    );

    // load writes straight from the ingress head, macc from the pe
    always_comb begin
        if (op_q == OP_MACC) begin
            wr_addr = pe_addr;
            wr_data = pe_result;
            wr_mask = {LANES{pe_valid}};
        end else begin
            wr_addr = seq_wr_addr;
            wr_data = i_beat;
            wr_mask = o_pop ? i_keep : '0;
        end
    end

    vec_regfile u_rf (
        .clk       (clk),
        .i_rd_addr1(rd_src),
        .i_rd_addr2(rd_dst),
        .o_rd_data1(rd_data1),
        .o_rd_data2(rd_data2),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_wr_mask (wr_mask)
    );

    macc_pe u_pe (
        .clk     (clk),
        .rst     (rst),
        .i_valid (macc_valid_q),
        .i_stream(beat_q),
        .i_mul   (rd_data1),
        .i_acc   (rd_data2),
        .i_addr  (rd_dst_q),
        .o_valid (pe_valid),
        .o_result(pe_result),
        .o_addr  (pe_addr)
    );

    always_comb begin
        o_chain = i_chain;  // idle column passes upstream beats along
        if (so_valid_q) begin
            o_chain.data  = rd_data1;
            o_chain.valid = '1;
            o_chain.last  = so_last_q;
        end
    end

endmodule

// ==== logic/vec_datapath.sv ====
module vec_datapath
    import vec_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    // stream in
    input  beat_t             i_in_tdata,
    input  logic [KEEP_W-1:0] i_in_tkeep,
    input  logic              i_in_tvalid,
    input  logic              i_in_tlast,  // framing comes from cmd len
    output logic              o_in_tready,
    // stream out
    output beat_t             o_out_tdata,
    output logic [KEEP_W-1:0] o_out_tkeep,
    output logic              o_out_tvalid,
    output logic              o_out_tlast,
    input  logic              i_out_tready,
    // loader and commands
    input  logic              i_done_loader,
    input  cmd_t              i_cmd,
    input  logic              i_cmd_valid,
    output logic              o_busy,
    output logic              o_done,
    output logic              o_armed
);

    typedef enum logic {
        LDR_OFF,
        LDR_ON
    } ldr_state_e;

    ldr_state_e         ldr_q;
    ldr_state_e         ldr_d;
    cmd_t               cmd_q;
    logic               busy_q;
    logic               accept;
    logic [NUM_COL-1:0] col_start;
    logic [NUM_COL-1:0] col_pop;
    logic [NUM_COL-1:0] col_done;
    beat_t              in_beat;
    lane_mask_t         in_keep;
    logic               in_avail;
    logic               out_stall;
    chain_t             chain [NUM_COL+1];
    out_lane_t          out_push_data [LANES];
    out_lane_t          out_head      [LANES];
    lane_mask_t         out_full;
    lane_mask_t         out_empty;
    lane_mask_t         out_last;
    logic               out_pop;

    // loader gate, steady-on between the loader pulse and the last command
    always_comb begin
        case (ldr_q)
            LDR_OFF: ldr_d = i_done_loader ? LDR_ON : LDR_OFF;
            LDR_ON:  ldr_d = (o_done && cmd_q.last) ? LDR_OFF : LDR_ON;
            default: ldr_d = LDR_OFF;
        endcase
    end

    assign o_armed = (ldr_q == LDR_ON);
    assign o_done  = |col_done;
    assign o_busy  = busy_q && !o_done;
    assign accept  = i_cmd_valid && o_armed && !o_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            ldr_q     <= LDR_OFF;
            cmd_q     <= '0;
            busy_q    <= 1'b0;
            col_start <= '0;
        end else begin
            ldr_q <= ldr_d;
            if (accept) cmd_q <= i_cmd;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (o_done) begin
                busy_q <= 1'b0;
            end
            for (int j = 0; j < NUM_COL; j++) begin
                col_start[j] <= accept && (i_cmd.col == 1'(j));
            end
        end
    end

    stream_ingress u_ingress (
        .clk     (clk),
        .rst     (rst),
        .i_tdata (i_in_tdata),
        .i_tkeep (i_in_tkeep),
        .i_tvalid(i_in_tvalid),
        .i_armed (o_armed),
        .o_tready(o_in_tready),
        .i_pop   (|col_pop),
        .o_beat  (in_beat),
        .o_keep  (in_keep),
        .o_avail (in_avail)
    );

    // a registered read keeps one beat in flight, so stall while it lands
    assign out_stall = |out_full || |chain[NUM_COL].valid;
    assign chain[0]  = '0;

    for (genvar j = 0; j < NUM_COL; j++) begin : g_col
        vec_column u_col (
            .clk       (clk),
            .rst       (rst),
            .i_start   (col_start[j]),
            .i_cmd     (cmd_q),
            .i_beat    (in_beat),
            .i_keep    (in_keep),
            .i_avail   (in_avail),
            .o_pop     (col_pop[j]),
            .i_out_full(out_stall),
            .i_chain   (chain[j]),
            .o_chain   (chain[j+1]),
            .o_done    (col_done[j])
        );
    end

    assign out_pop = o_out_tvalid && i_out_tready;

    for (genvar l = 0; l < LANES; l++) begin : g_out
        assign out_push_data[l].data = chain[NUM_COL].data[l];
        assign out_push_data[l].last = chain[NUM_COL].last;

        lane_fifo #(
            .payload_t(out_lane_t),
            .DEPTH    (FIFO_DEPTH)
        ) u_fifo (
            .clk    (clk),
            .rst    (rst),
            .i_push (chain[NUM_COL].valid[l]),
            .i_data (out_push_data[l]),
            .i_pop  (out_pop),
            .o_data (out_head[l]),
            .o_empty(out_empty[l]),
            .o_full (out_full[l])
        );

        assign o_out_tdata[l]        = out_head[l].data;
        assign out_last[l]           = out_head[l].last;
        assign o_out_tkeep[4*l +: 4] = {4{!out_empty[l]}};
    end

    assign o_out_tvalid = !(|out_empty);
    assign o_out_tlast  = &out_last;

endmodule

// ==== testbench/tb_vec_datapath.sv ====
module tb_vec_datapath
    import vec_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;   // inputs move this long after the rising edge
    localparam int RST_CYCLES = 16;
    localparam int TIMEOUT    = 500;  // cycles allowed for any single wait
    localparam int MAX_ROWS   = 16;
    localparam int RDY_HIGH   = 0;
    localparam int RDY_HOLD   = 1;
    localparam int RDY_RAND   = 2;

    logic              clk;
    logic              rst;
    beat_t             i_in_tdata;
    logic [KEEP_W-1:0] i_in_tkeep;
    logic              i_in_tvalid;
    logic              i_in_tlast;
    logic              o_in_tready;
    beat_t             o_out_tdata;
    logic [KEEP_W-1:0] o_out_tkeep;
    logic              o_out_tvalid;
    logic              o_out_tlast;
    logic              i_out_tready;
    logic              i_done_loader;
    cmd_t              i_cmd;
    logic              i_cmd_valid;
    logic              o_busy;
    logic              o_done;
    logic              o_armed;

    // command table, one row per test
    cmd_t              row_cmd   [MAX_ROWS];
    logic [KEEP_W-1:0] row_keep  [MAX_ROWS];
    int                row_ready [MAX_ROWS];
    logic [31:0]       row_pat   [MAX_ROWS];
    logic              row_rearm [MAX_ROWS];
    beat_t             row_in    [MAX_ROWS][RF_DEPTH];
    beat_t             row_exp   [MAX_ROWS][RF_DEPTH];
    beat_t             model     [NUM_COL][RF_DEPTH];  // expected register contents
    int                n_rows;

    beat_t       got_data [$];
    logic        got_last [$];
    logic        got_keep [$];
    int          ready_mode;
    logic [31:0] ready_pat;
    int          errors;
    int          tests;
    int          failed_tests;
    logic        timed_out;

    vec_datapath DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // output ready, mode taken at the edge so it never races the main thread
    initial begin
        int         mode_now;
        logic [4:0] pat_idx;
        i_out_tready = 1'b0;
        pat_idx = '0;
        forever begin
            @(posedge clk);
            mode_now = ready_mode;
            #DRIVE_DLY;
            if (mode_now == RDY_HIGH) i_out_tready = 1'b1;
            else if (mode_now == RDY_HOLD) i_out_tready = 1'b0;
            else i_out_tready = ready_pat[pat_idx];
            pat_idx = pat_idx + 5'd1;
        end
    end

    always @(negedge clk) begin
        if (!rst && o_out_tvalid && i_out_tready) begin  // taken at the next edge
            got_data.push_back(o_out_tdata);
            got_last.push_back(o_out_tlast);
            got_keep.push_back(&o_out_tkeep);
        end
    end

    task automatic check_beat(input string name, input beat_t got, input beat_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // appends a row and runs the register model over it
    task automatic add_row(input op_e op, input int col, input int src, input int dst,
                           input int len, input logic [KEEP_W-1:0] keep, input logic last,
                           input logic rearm, input int ready);
        cmd_t              c;
        int                r;
        logic [ADDR_W-1:0] sa;
        logic [ADDR_W-1:0] da;
        r = n_rows;
        c.op   = op;
        c.col  = col[0];
        c.src  = src[ADDR_W-1:0];
        c.dst  = dst[ADDR_W-1:0];
        c.len  = len[CNT_W-1:0];
        c.last = last;
        row_cmd[r]   = c;
        row_keep[r]  = keep;
        row_ready[r] = ready;
        row_pat[r]   = $urandom | 32'h0000_0101;
        row_rearm[r] = rearm;
        for (int k = 0; k < len; k++) begin
            sa = c.src + k[ADDR_W-1:0];  // addresses wrap at RF_DEPTH
            da = c.dst + k[ADDR_W-1:0];
            for (int l = 0; l < LANES; l++) row_in[r][k][l] = $urandom;
            if (op == OP_LOAD) begin
                for (int l = 0; l < LANES; l++) begin
                    if (&keep[4*l +: 4]) model[col][da][l] = row_in[r][k][l];
                end
            end else if (op == OP_MACC) begin
                for (int l = 0; l < LANES; l++) begin
                    model[col][da][l] = model[col][da][l] + row_in[r][k][l] * model[col][sa][l];
                end
            end else begin
                row_exp[r][k] = model[col][sa];
            end
        end
        n_rows++;
    endtask

    task automatic send_beat(input beat_t data, input logic [KEEP_W-1:0] keep, input logic last);
        int waited;
        i_in_tdata  = data;
        i_in_tkeep  = keep;
        i_in_tlast  = last;
        i_in_tvalid = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!o_in_tready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!o_in_tready) begin
            timed_out = 1'b1;
            $display("timeout: input beat never accepted, o_in_tready stayed low");
        end
        step();
        i_in_tvalid = 1'b0;
    endtask

    task automatic issue_cmd(input cmd_t c);
        i_cmd       = c;
        i_cmd_valid = 1'b1;
        step();
        i_cmd_valid = 1'b0;
        check_bit("o_busy", o_busy, 1'b1);
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!o_done && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!o_done) begin
            timed_out = 1'b1;
            $display("timeout: command never signalled o_done");
            return;
        end
        check_bit("o_busy", o_busy, 1'b0);  // falls with the done pulse
        step();
        check_bit("o_done", o_done, 1'b0);  // single-cycle pulse
    endtask

    task automatic wait_beats(input int n);
        int waited;
        waited = 0;
        while (got_data.size() < n && waited < TIMEOUT) begin
            step();
            waited++;
        end
        if (got_data.size() < n) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d output beats arrived", got_data.size(), n);
        end
    endtask

    // offered beat and command must both be ignored until the loader pulse
    task automatic gate_and_arm(input cmd_t probe);
        i_in_tvalid = 1'b1;
        i_cmd       = probe;
        i_cmd_valid = 1'b1;
        step();
        i_cmd_valid = 1'b0;
        for (int n = 0; n < 4; n++) begin
            check_bit("o_armed", o_armed, 1'b0);
            check_bit("o_in_tready", o_in_tready, 1'b0);
            check_bit("o_busy", o_busy, 1'b0);
            step();
        end
        i_in_tvalid   = 1'b0;
        i_done_loader = 1'b1;
        step();
        i_done_loader = 1'b0;
        check_bit("o_armed", o_armed, 1'b1);
        check_bit("o_in_tready", o_in_tready, 1'b1);
    endtask

    task automatic run_row(input int r);
        cmd_t c;
        int   len;
        c   = row_cmd[r];
        len = int'(c.len);
        if (row_rearm[r]) begin
            gate_and_arm(c);
        end
        if (c.op != OP_STREAMOUT) begin
            for (int k = 0; k < len && !timed_out; k++) begin
                send_beat(row_in[r][k], row_keep[r], k == len - 1);
            end
        end else begin
            ready_mode = row_ready[r];
            ready_pat  = row_pat[r];
            got_data.delete();
            got_last.delete();
            got_keep.delete();
        end
        if (timed_out) return;
        issue_cmd(c);
        wait_done();
        if (timed_out) return;
        check_bit("o_armed", o_armed, !c.last);  // a last command disarms the loader
        if (c.op != OP_STREAMOUT) return;
        if (ready_mode == RDY_HOLD) begin
            repeat (20) step();
            if (got_data.size() != 0) begin
                errors++;
                $display("output beats left while i_out_tready was held low");
            end
            check_bit("o_out_tvalid", o_out_tvalid, 1'b1);
            ready_mode = RDY_HIGH;
        end
        wait_beats(len);
        repeat (6) step();  // a duplicate beat would land here
        if (got_data.size() != len) begin
            errors++;
            $display("got %0d output beats, expected %0d", got_data.size(), len);
        end
        for (int k = 0; k < len && k < got_data.size(); k++) begin
            check_beat($sformatf("o_out_tdata[%0d]", k), got_data[k], row_exp[r][k]);
            check_bit($sformatf("o_out_tlast[%0d]", k), got_last[k], k == len - 1);
            check_bit($sformatf("o_out_tkeep[%0d] all set", k), got_keep[k], 1'b1);
        end
        ready_mode = RDY_HIGH;
    endtask

    task automatic close_test(input string what, input int errs_before);
        tests++;
        if (errors != errs_before) failed_tests++;
        $display("test %0d %s: %s", tests, what, (errors == errs_before) ? "pass" : "mismatch");
    endtask

    initial begin
        int   errs_before;
        cmd_t probe;
        op_e  op;
        rst           = 1'b1;
        i_in_tdata    = '0;
        i_in_tkeep    = '0;
        i_in_tvalid   = 1'b0;
        i_in_tlast    = 1'b0;
        i_done_loader = 1'b0;
        i_cmd         = '0;
        i_cmd_valid   = 1'b0;
        ready_mode    = RDY_HIGH;
        ready_pat     = '1;
        errors        = 0;
        tests         = 0;
        failed_tests  = 0;
        timed_out     = 1'b0;
        n_rows        = 0;
        void'($urandom(32'haedd));

        //      op            col src dst len keep      last  rearm ready
        add_row(OP_LOAD,      0,  0,  0,  16, 16'hFFFF, 1'b0, 1'b0, RDY_HIGH);
        add_row(OP_LOAD,      1,  0,  0,  16, 16'hFFFF, 1'b0, 1'b0, RDY_HIGH);
        add_row(OP_STREAMOUT, 0,  0,  0,  16, 16'hFFFF, 1'b0, 1'b0, RDY_HIGH);
        add_row(OP_STREAMOUT, 1,  0,  0,  16, 16'hFFFF, 1'b0, 1'b0, RDY_RAND);
        add_row(OP_LOAD,      0,  0,  4,  5,  16'h0F0F, 1'b0, 1'b0, RDY_HIGH);
        add_row(OP_STREAMOUT, 0,  2,  0,  8,  16'hFFFF, 1'b0, 1'b0, RDY_HIGH);
        add_row(OP_MACC,      1,  0,  8,  8,  16'hFFFF, 1'b0, 1'b0, RDY_HIGH);
        add_row(OP_STREAMOUT, 1,  8,  0,  8,  16'hFFFF, 1'b0, 1'b0, RDY_RAND);
        add_row(OP_MACC,      0,  12, 0,  4,  16'hFFFF, 1'b0, 1'b0, RDY_HIGH);
        add_row(OP_STREAMOUT, 0,  0,  0,  16, 16'hFFFF, 1'b0, 1'b0, RDY_HOLD);
        add_row(OP_LOAD,      1,  0,  14, 4,  16'hF0FF, 1'b0, 1'b0, RDY_HIGH);
        add_row(OP_STREAMOUT, 1,  12, 0,  6,  16'hFFFF, 1'b1, 1'b0, RDY_HIGH);
        add_row(OP_STREAMOUT, 1,  0,  0,  16, 16'hFFFF, 1'b0, 1'b1, RDY_RAND);

        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        errs_before = errors;
        check_bit("o_armed", o_armed, 1'b0);
        check_bit("o_busy", o_busy, 1'b0);
        check_bit("o_done", o_done, 1'b0);
        check_bit("o_in_tready", o_in_tready, 1'b0);
        check_bit("o_out_tvalid", o_out_tvalid, 1'b0);
        probe = row_cmd[0];
        gate_and_arm(probe);
        close_test("reset values and loader gate", errs_before);

        for (int r = 0; r < n_rows && !timed_out; r++) begin
            errs_before = errors;
            run_row(r);
            op = row_cmd[r].op;
            close_test($sformatf("%s col%0d src%0d dst%0d len%0d", op.name(), row_cmd[r].col,
                                 row_cmd[r].src, row_cmd[r].dst, row_cmd[r].len),
                       errs_before);
        end

        $display("%0d tests run, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
logic/vec_pkg.sv
logic/lane_fifo.sv
logic/stream_ingress.sv
logic/addr_sequencer.sv
logic/vec_regfile.sv
logic/macc_pe.sv
logic/vec_column.sv
logic/vec_datapath.sv
testbench/tb_vec_datapath.sv

// ==== Makefile ====
TOP := tb_vec_datapath

obj_dir/V$(TOP): build.f $(wildcard logic/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
